// File: rtl/div_pkg.sv
package div_pkg;

    // word width of the core
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;

    // bit 0 set means unsigned, bit 1 set means remainder
    typedef logic [1:0] div_op_t;

    localparam div_op_t DIV_OP_DIV  = 2'b00;
    localparam div_op_t DIV_OP_DIVU = 2'b01;
    localparam div_op_t DIV_OP_REM  = 2'b10;
    localparam div_op_t DIV_OP_REMU = 2'b11;

    // one operation as issued by the core
    typedef struct packed {
        div_op_t op;
        xlen_t   dividend;
        xlen_t   divisor;
    } div_req_t;

    // result fixes, carried untouched down the cell chain
    typedef struct packed {
        logic neg_q;   // negate quotient
        logic neg_r;   // negate remainder
        logic sel_rem; // remainder out instead of quotient
    } div_flags_t;

    // state of one operation between two pipeline stages
    typedef struct packed {
        logic       valid;
        div_flags_t flags;
        xlen_t      rem;   // partial remainder
        xlen_t      dvd;   // dividend bits left, msb first
        xlen_t      dsr;   // absolute divisor
        xlen_t      quo;   // quotient so far
    } div_stage_t;

endpackage

// File: rtl/div_cell.sv
`timescale 1ns/1ps

module div_cell (
    input  logic                clk,
    input  logic                rstn,
    input  div_pkg::div_stage_t stage_in,
    output div_pkg::div_stage_t stage_out
);
    import div_pkg::*;

    logic [XLEN:0] rem_wide;
    logic [XLEN:0] dsr_wide;
    logic [XLEN:0] rem_diff;
    logic          take;
    xlen_t         rem_next;
    xlen_t         dvd_next;
    xlen_t         quo_next;

    logic          valid_q;
    div_flags_t    flags_q;
    xlen_t         rem_q;
    xlen_t         dvd_q;
    xlen_t         dsr_q;
    xlen_t         quo_q;

    // bring down next dividend bit
    assign rem_wide = {stage_in.rem, stage_in.dvd[XLEN-1]};
    assign dsr_wide = {1'b0, stage_in.dsr};
    assign rem_diff = rem_wide - dsr_wide;

    assign take = (rem_wide >= dsr_wide); // always true for zero divisor

    // difference fits in XLEN bits since rem < dsr before the step
    assign rem_next = take ? rem_diff[XLEN-1:0] : rem_wide[XLEN-1:0];
    assign dvd_next = {stage_in.dvd[XLEN-2:0], 1'b0};
    assign quo_next = {stage_in.quo[XLEN-2:0], take};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= stage_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (stage_in.valid) begin
            flags_q <= stage_in.flags;  // passed through
            rem_q   <= rem_next;
            dvd_q   <= dvd_next;
            dsr_q   <= stage_in.dsr;
            quo_q   <= quo_next;
        end
    end

    always_comb begin
        stage_out.valid = valid_q;
        stage_out.flags = flags_q;
        stage_out.rem   = rem_q;
        stage_out.dvd   = dvd_q;
        stage_out.dsr   = dsr_q;
        stage_out.quo   = quo_q;
    end

endmodule

// File: rtl/div_array.sv
`timescale 1ns/1ps

module div_array (
    input  logic                clk,
    input  logic                rstn,
    input  div_pkg::div_stage_t array_in,
    output div_pkg::div_stage_t array_out
);
    import div_pkg::*;

    // link k feeds cell k, link XLEN is the last cell output
    div_stage_t links [0:XLEN];

    assign links[0]  = array_in;
    assign array_out = links[XLEN];

    // one quotient bit per cell, msb first
    for (genvar k = 0; k < XLEN; k++) begin : g_cell
        div_cell u_cell (
            .clk       (clk),
            .rstn      (rstn),
            .stage_in  (links[k]),
            .stage_out (links[k+1])
        );
    end

endmodule

// File: rtl/div_operand_prep.sv
`timescale 1ns/1ps

module div_operand_prep (
    input  logic                clk,
    input  logic                rstn,
    input  logic                div_valid,
    input  div_pkg::div_req_t   div_req,
    output div_pkg::div_stage_t prep_out
);
    import div_pkg::*;

    logic       is_signed;
    logic       dvd_neg;
    logic       dsr_neg;
    logic       dsr_zero;
    xlen_t      dvd_abs;
    xlen_t      dsr_abs;
    div_flags_t flags_d;

    logic       valid_q;
    div_flags_t flags_q;
    xlen_t      dvd_q;
    xlen_t      dsr_q;

    assign is_signed = ~div_req.op[0];
    assign dvd_neg   = is_signed & div_req.dividend[XLEN-1];
    assign dsr_neg   = is_signed & div_req.divisor[XLEN-1];
    assign dsr_zero  = (div_req.divisor == '0);

    // most negative value maps onto itself
    assign dvd_abs = dvd_neg ? (~div_req.dividend + xlen_t'(1)) : div_req.dividend;
    assign dsr_abs = dsr_neg ? (~div_req.divisor + xlen_t'(1)) : div_req.divisor;

    // zero divisor keeps quotient all ones
    assign flags_d.neg_q   = (dvd_neg ^ dsr_neg) & ~dsr_zero;
    assign flags_d.neg_r   = dvd_neg;
    assign flags_d.sel_rem = div_req.op[1];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= div_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (div_valid) begin
            flags_q <= flags_d;
            dvd_q   <= dvd_abs;
            dsr_q   <= dsr_abs;
        end
    end

    always_comb begin
        prep_out.valid = valid_q;
        prep_out.flags = flags_q;
        prep_out.rem   = '0;       // cleared for first step
        prep_out.dvd   = dvd_q;
        prep_out.dsr   = dsr_q;
        prep_out.quo   = '0;
    end

endmodule

// File: rtl/div_result_fix.sv
`timescale 1ns/1ps

module div_result_fix (
    input  logic                clk,
    input  logic                rstn,
    input  div_pkg::div_stage_t stage_in,
    output logic                res_valid,
    output div_pkg::xlen_t      res_data
);
    import div_pkg::*;

    xlen_t quo_fixed;
    xlen_t rem_fixed;
    xlen_t res_sel;

    assign quo_fixed = stage_in.flags.neg_q ? (~stage_in.quo + xlen_t'(1)) : stage_in.quo;
    assign rem_fixed = stage_in.flags.neg_r ? (~stage_in.rem + xlen_t'(1)) : stage_in.rem;

    assign res_sel = stage_in.flags.sel_rem ? rem_fixed : quo_fixed;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= stage_in.valid;
        end
    end

    // held until the next result
    always_ff @(posedge clk) begin
        if (stage_in.valid) begin
            res_data <= res_sel;
        end
    end

endmodule

// File: rtl/div_unit.sv
`timescale 1ns/1ps

module div_unit (
    input  logic              clk,
    input  logic              rstn,
    input  logic              div_valid,
    input  div_pkg::div_req_t div_req,
    output logic              res_valid,
    output div_pkg::xlen_t    res_data
);
    import div_pkg::*;

    div_stage_t prep_stage;
    div_stage_t last_stage;

    // 1 cycle
    div_operand_prep u_prep (
        .clk       (clk),
        .rstn      (rstn),
        .div_valid (div_valid),
        .div_req   (div_req),
        .prep_out  (prep_stage)
    );

    // XLEN cycles
    div_array u_array (
        .clk       (clk),
        .rstn      (rstn),
        .array_in  (prep_stage),
        .array_out (last_stage)
    );

    // 1 cycle, XLEN+2 in total
    div_result_fix u_fix (
        .clk       (clk),
        .rstn      (rstn),
        .stage_in  (last_stage),
        .res_valid (res_valid),
        .res_data  (res_data)
    );

endmodule

// File: sim/div_unit_tb.sv
`timescale 1ns/1ps

module div_unit_tb;
    import div_pkg::*;

    localparam int NVEC    = 27;
    localparam int NRAND   = 200;
    localparam int LATENCY = XLEN + 2;

    typedef struct packed {
        div_op_t    op;
        xlen_t      a;
        xlen_t      b;
        xlen_t      exp;
        logic [7:0] gap;  // idle cycles after the entry
        logic       rst;  // reset while this entry is in flight
    } vec_t;

    logic     clk = 1'b0;
    logic     rstn;
    logic     div_valid;
    div_req_t div_req;
    logic     res_valid;
    xlen_t    res_data;

    vec_t     vecs [NVEC];
    xlen_t    exp_q [$];
    int       cyc_q [$];
    int       cyc = 0;
    int       errors = 0;
    int       checks = 0;
    int       issued = 0;
    int       results = 0;
    int       err_mark;
    xlen_t    exp_val;
    int       issue_cyc;
    logic [31:0] seed;
    div_op_t  r_op;
    xlen_t    r_a;
    xlen_t    r_b;

    div_unit dut (
        .clk       (clk),
        .rstn      (rstn),
        .div_valid (div_valid),
        .div_req   (div_req),
        .res_valid (res_valid),
        .res_data  (res_data)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // riscv M results, zero divisor and overflow included
    function automatic xlen_t ref_result(input div_op_t op, input xlen_t a, input xlen_t b);
        logic  sgn;
        xlen_t q;
        xlen_t r;
        sgn = (op == DIV_OP_DIV) || (op == DIV_OP_REM);
        if (b == '0) begin
            q = '1;
            r = a;
        end else if (sgn && a == 32'h8000_0000 && b == '1) begin
            q = a;
            r = '0;
        end else if (sgn) begin
            q = $signed(a) / $signed(b);  // truncates toward zero
            r = $signed(a) % $signed(b);
        end else begin
            q = a / b;
            r = a % b;
        end
        return (op == DIV_OP_REM || op == DIV_OP_REMU) ? r : q;
    endfunction

    task automatic fill_table();
        vecs[0]  = '{DIV_OP_DIVU, 32'd100, 32'd7, 32'd14, 8'd0, 1'b0};
        vecs[1]  = '{DIV_OP_REMU, 32'd100, 32'd7, 32'd2, 8'd0, 1'b0};
        vecs[2]  = '{DIV_OP_DIVU, 32'h1234_5678, 32'd1, 32'h1234_5678, 8'd0, 1'b0};
        vecs[3]  = '{DIV_OP_REMU, 32'd5, 32'd9, 32'd5, 8'd0, 1'b0};
        vecs[4]  = '{DIV_OP_DIVU, 32'd5, 32'd9, 32'd0, 8'd0, 1'b0};
        vecs[5]  = '{DIV_OP_DIVU, 32'hffff_ffff, 32'hffff_ffff, 32'd1, 8'd0, 1'b0};
        vecs[6]  = '{DIV_OP_REMU, 32'hffff_ffff, 32'hffff_ffff, 32'd0, 8'd0, 1'b0};
        vecs[7]  = '{DIV_OP_DIVU, 32'hffff_ffff, 32'd2, 32'h7fff_ffff, 8'd3, 1'b0};
        vecs[8]  = '{DIV_OP_DIV, 32'd7, 32'd2, 32'd3, 8'd0, 1'b0};
        vecs[9]  = '{DIV_OP_DIV, 32'hffff_fff9, 32'd2, 32'hffff_fffd, 8'd0, 1'b0};
        vecs[10] = '{DIV_OP_DIV, 32'd7, 32'hffff_fffe, 32'hffff_fffd, 8'd0, 1'b0};
        vecs[11] = '{DIV_OP_DIV, 32'hffff_fff9, 32'hffff_fffe, 32'd3, 8'd0, 1'b0};
        vecs[12] = '{DIV_OP_REM, 32'd7, 32'd2, 32'd1, 8'd0, 1'b0};
        vecs[13] = '{DIV_OP_REM, 32'hffff_fff9, 32'd2, 32'hffff_ffff, 8'd0, 1'b0};
        vecs[14] = '{DIV_OP_REM, 32'd7, 32'hffff_fffe, 32'd1, 8'd0, 1'b0};
        vecs[15] = '{DIV_OP_REM, 32'hffff_fff9, 32'hffff_fffe, 32'hffff_ffff, 8'd5, 1'b0};
        vecs[16] = '{DIV_OP_DIV, 32'h0000_1234, 32'd0, 32'hffff_ffff, 8'd0, 1'b0};
        vecs[17] = '{DIV_OP_DIVU, 32'h0000_1234, 32'd0, 32'hffff_ffff, 8'd0, 1'b0};
        vecs[18] = '{DIV_OP_REM, 32'hffff_fff9, 32'd0, 32'hffff_fff9, 8'd0, 1'b0};
        vecs[19] = '{DIV_OP_REMU, 32'hffff_fff9, 32'd0, 32'hffff_fff9, 8'd1, 1'b0};
        vecs[20] = '{DIV_OP_DIV, 32'h8000_0000, 32'hffff_ffff, 32'h8000_0000, 8'd0, 1'b0};
        vecs[21] = '{DIV_OP_REM, 32'h8000_0000, 32'hffff_ffff, 32'd0, 8'd0, 1'b0};
        vecs[22] = '{DIV_OP_DIVU, 32'h8000_0000, 32'hffff_ffff, 32'd0, 8'd0, 1'b0};
        vecs[23] = '{DIV_OP_REMU, 32'h8000_0000, 32'hffff_ffff, 32'h8000_0000, 8'd2, 1'b0};
        vecs[24] = '{DIV_OP_DIV, 32'h8000_0000, 32'd1, 32'h8000_0000, 8'd0, 1'b0};
        vecs[25] = '{DIV_OP_DIVU, 32'd1000, 32'd10, 32'd100, 8'd10, 1'b1};
        vecs[26] = '{DIV_OP_DIVU, 32'd1000, 32'd10, 32'd100, 8'd0, 1'b0};
    endtask

    // op sampled on the next edge, which the checker counts as cyc
    task automatic issue_op(input div_op_t op, input xlen_t a, input xlen_t b,
                            input xlen_t exp, input bit track);
        @(posedge clk);
        #1;
        div_valid        = 1'b1;
        div_req.op       = op;
        div_req.dividend = a;
        div_req.divisor  = b;
        if (track) begin
            exp_q.push_back(exp);
            cyc_q.push_back(cyc);
            issued++;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            div_valid = 1'b0;
        end
    endtask

    task automatic hold_reset();
        repeat (8) begin
            @(posedge clk);
            checks++;
            assert (res_valid === 1'b0) else begin
                $display("CHECK FAILED: res_valid got %h expected 0 during reset", res_valid);
                errors++;
            end
        end
        #1;
        rstn = 1'b1;
    endtask

    always @(posedge clk) begin
        if (res_valid) begin
            if (exp_q.size() == 0) begin
                $display("extra result %h arrived with no operation outstanding", res_data);
                errors++;
            end else begin
                exp_val   = exp_q.pop_front();
                issue_cyc = cyc_q.pop_front();
                results++;
                checks += 2;
                assert (res_data === exp_val) else begin
                    $display("CHECK FAILED: res_data got %h expected %h", res_data, exp_val);
                    errors++;
                end
                assert (cyc == issue_cyc + LATENCY) else begin
                    $display("CHECK FAILED: res_valid cycle got %h expected %h",
                             cyc, issue_cyc + LATENCY);
                    errors++;
                end
            end
        end
        cyc = cyc + 1;
    end

    // bound from the table length, gaps and reset sequences
    initial begin : watchdog
        int limit;
        #1;
        limit = 48;
        for (int i = 0; i < NVEC; i++) begin
            limit += 1 + int'(vecs[i].gap);
            if (vecs[i].rst) limit += LATENCY + 8 + 40;
        end
        limit += LATENCY;  // table drain
        limit += NRAND + LATENCY + 50;
        #(limit * 8);
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("sim failed");
        $finish;
    end

    initial begin
        rstn      = 1'b0;
        div_valid = 1'b0;
        div_req   = '0;
        fill_table();

        err_mark = errors;
        hold_reset();
        idle_cycles(40);  // nothing may come out
        $display("test reset idle: %0d errors", errors - err_mark);

        err_mark = errors;
        for (int i = 0; i < NVEC; i++) begin
            if (vecs[i].rst) begin
                idle_cycles(1);
                while (exp_q.size() != 0) @(posedge clk);
                issue_op(vecs[i].op, vecs[i].a, vecs[i].b, vecs[i].exp, 1'b0);
                idle_cycles(int'(vecs[i].gap));
                @(posedge clk);
                #1;
                rstn = 1'b0;
                hold_reset();
                idle_cycles(40);  // discarded op must not appear
                $display("test reset in flight: entry %0d done", i);
            end else begin
                issue_op(vecs[i].op, vecs[i].a, vecs[i].b, vecs[i].exp, 1'b1);
                idle_cycles(int'(vecs[i].gap));
            end
        end
        idle_cycles(1);
        while (exp_q.size() != 0) @(posedge clk);
        $display("test directed table: %0d errors", errors - err_mark);

        err_mark = errors;
        seed = 32'h1117;
        repeat (NRAND) begin
            seed = lcg_next(seed);
            r_op = seed[17:16];
            seed = lcg_next(seed);
            r_a  = seed;
            seed = lcg_next(seed);
            r_b  = seed;
            case (seed[30:28])
                3'd0: r_b = '0;
                3'd1: begin
                    r_a = 32'h8000_0000;
                    r_b = '1;
                end
                3'd2: r_b = r_b >> 20;  // small divisor
                3'd3: r_a = r_a >> 16;
                default: ;
            endcase
            issue_op(r_op, r_a, r_b, ref_result(r_op, r_a, r_b), 1'b1);
        end
        idle_cycles(LATENCY + 10);
        $display("test random stream: %0d errors", errors - err_mark);

        if (exp_q.size() != 0) begin
            $display("missing results: %0d operations never produced a result", exp_q.size());
            errors += exp_q.size();
        end
        $display("issued %0d results %0d checks %0d errors %0d", issued, results, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: all.f
rtl/div_pkg.sv
rtl/div_cell.sv
rtl/div_array.sv
rtl/div_operand_prep.sv
rtl/div_result_fix.sv
rtl/div_unit.sv
sim/div_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the divider testbench with Verilator.
set -e

cd "$(dirname "$0")"

OBJ_DIR=obj_dir
LOG=sim.log

rm -rf "$OBJ_DIR"

verilator --binary --timing --assert \
    -f all.f \
    --top-module div_unit_tb \
    --Mdir "$OBJ_DIR" \
    -o div_unit_sim

"./$OBJ_DIR/div_unit_sim" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qx "sim passed" "$LOG"; then
    echo "result: pass"
    exit 0
else
    echo "result: fail"
    exit 1
fi
